// File: rtl/cache_pkg.sv
// Cache geometry and the structs shared by the cache blocks.
// Imported by the controller, the line mover and the top level.
`default_nettype none

package cache_pkg;

	// Address split of the 16-bit word address
	localparam int WORD_BITS  = 2;
	localparam int SET_BITS   = 4;
	localparam int TAG_BITS   = 10;
	localparam int LINE_WORDS = 4;

	typedef logic [15:0] word_adr_t;

	typedef struct packed {
		logic [TAG_BITS-1:0]  tag;
		logic [SET_BITS-1:0]  set;
		logic [WORD_BITS-1:0] word;
	} adr_fields_t;

	// One entry per set, lru set means way 0 is the next victim
	typedef struct packed {
		logic [TAG_BITS-1:0] tag0;
		logic [TAG_BITS-1:0] tag1;
		logic                dirty0;
		logic                dirty1;
		logic                lru;
	} tag_line_t;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		word_adr_t   adr;
		logic [31:0] dat;
		logic [3:0]  sel;
	} bus_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} bus_rsp_t;

	// Miss command from the controller to the line mover
	typedef struct packed {
		logic                fill;
		logic                spill;
		logic                way;
		logic [TAG_BITS-1:0] tag;
		logic [SET_BITS-1:0] set;
	} line_cmd_t;

endpackage

`default_nettype wire

// File: rtl/mem_link_pkg.sv
// Word transfer structs of the four-phase memory link.
// One req/ack handshake moves a single 32-bit word.
`default_nettype none

package mem_link_pkg;

	typedef struct packed {
		logic        req;
		logic        we;
		logic [15:0] adr;
		logic [31:0] wdat;
	} mem_req_t;

	// rdat is valid while ack is high on a read
	typedef struct packed {
		logic        ack;
		logic [31:0] rdat;
	} mem_rsp_t;

endpackage

`default_nettype wire

// File: rtl/cache_dpram.sv
// Two-port synchronous RAM with one cycle of read latency.
// The payload type is a parameter, so tag lines and data words share it.
`timescale 1ns/1ps
`default_nettype none

module cache_dpram #(
	parameter int  adr_width = 4,
	parameter type payload_t = logic [31:0]
) (
	input  wire logic                 clk,
	input  wire logic [adr_width-1:0] adr0_i,
	input  wire payload_t             din0_i,
	input  wire logic                 we0_i,
	output payload_t                  dout0_o,
	input  wire logic [adr_width-1:0] adr1_i,
	input  wire payload_t             din1_i,
	input  wire logic                 we1_i,
	output payload_t                  dout1_o
);

	payload_t mem [0:2**adr_width-1];

	// Write-first on each port, port 1 wins on a shared address
	always_ff @(posedge clk) begin
		if (we0_i) begin
			mem[adr0_i] <= din0_i;
			dout0_o     <= din0_i;
		end else begin
			dout0_o <= mem[adr0_i];
		end
		if (we1_i) begin
			mem[adr1_i] <= din1_i;
			dout1_o     <= din1_i;
		end else begin
			dout1_o <= mem[adr1_i];
		end
	end

endmodule

`default_nettype wire

// File: rtl/cache_ctrl.sv
// Bus-side controller of the two-way cache. Looks up both ways one cycle
// after the request, acks hits, merges write bytes and keeps LRU and dirty
// bits. Misses are handed to the line mover as spill and fill commands.
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire cache_pkg::bus_req_t  bus_req_i,
	output cache_pkg::bus_rsp_t       bus_rsp_o,
	input  wire cache_pkg::tag_line_t tag_i,
	output cache_pkg::tag_line_t      tag_o,
	output logic                      tag_we_o,
	input  wire logic [31:0]          way0_i,
	input  wire logic [31:0]          way1_i,
	output logic [31:0]               way_dat_o,
	output logic                      way0_we_o,
	output logic                      way1_we_o,
	output cache_pkg::line_cmd_t      cmd_o,
	input  wire logic                 busy_i
);

	import cache_pkg::*;

	typedef enum logic [2:0] {
		s_idle,
		s_read,
		s_rspill,
		s_rfill,
		s_write,
		s_wspill
	} state_t;

	state_t      state;
	adr_fields_t adr;
	logic        hit0;
	logic        hit1;
	logic        hit;
	logic        lookup;
	logic        victim_way;
	logic        victim_dirty;
	logic        busy;
	logic [31:0] hit_word;

	//------------------------------------------------------------------------
	// Tag compare and victim choice
	//------------------------------------------------------------------------
	assign adr  = bus_req_i.adr;
	assign hit0 = (tag_i.tag0 == adr.tag);
	assign hit1 = (tag_i.tag1 == adr.tag);
	assign hit  = hit0 | hit1;

	// Way 0 wins when both tags match
	assign hit_word = hit0 ? way0_i : way1_i;

	assign victim_way   = ~tag_i.lru;
	assign victim_dirty = victim_way ? tag_i.dirty1 : tag_i.dirty0;

	// The command pulse cycle counts as busy too
	assign busy = busy_i | cmd_o.fill | cmd_o.spill;

	assign lookup = (state == s_read) || (state == s_write);

	//------------------------------------------------------------------------
	// Bus FSM
	//------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_idle;
			cmd_o <= '0;
		end else begin
			cmd_o.fill  <= 1'b0;
			cmd_o.spill <= 1'b0;
			case (state)
			s_idle: begin
				if (bus_req_i.cyc && bus_req_i.stb)
					state <= bus_req_i.we ? s_write : s_read;
			end
			s_read, s_write: begin
				if (hit) begin
					state <= s_idle;
				end else if (!busy) begin
					cmd_o.way <= victim_way;
					cmd_o.set <= adr.set;
					if (victim_dirty) begin
						// Write back the victim first, then retry
						cmd_o.spill <= 1'b1;
						cmd_o.tag   <= victim_way ? tag_i.tag1 : tag_i.tag0;
						state       <= (state == s_read) ? s_rspill : s_wspill;
					end else begin
						cmd_o.fill <= 1'b1;
						cmd_o.tag  <= adr.tag;
						state      <= s_rfill;
					end
				end
			end
			s_rspill: begin
				if (!busy)
					state <= s_read;
			end
			s_wspill: begin
				if (!busy)
					state <= s_write;
			end
			s_rfill: begin
				// Fill wait serves both directions
				if (!busy)
					state <= bus_req_i.we ? s_write : s_read;
			end
			default: state <= s_idle;
			endcase
		end
	end

	//------------------------------------------------------------------------
	// Hit response, byte merge and tag update
	//------------------------------------------------------------------------
	always_comb begin
		tag_o         = tag_i;
		tag_we_o      = 1'b0;
		way0_we_o     = 1'b0;
		way1_we_o     = 1'b0;
		bus_rsp_o.ack = 1'b0;
		bus_rsp_o.dat = hit_word;

		for (int i = 0; i < 4; i++)
			way_dat_o[8*i +: 8] = bus_req_i.sel[i] ? bus_req_i.dat[8*i +: 8]
			                                       : hit_word[8*i +: 8];

		if (lookup && hit) begin
			bus_rsp_o.ack = 1'b1;
			tag_we_o      = 1'b1;
			// Victim becomes the other way
			tag_o.lru     = ~hit0;
			if (state == s_write) begin
				if (hit0) begin
					tag_o.tag0   = adr.tag;
					tag_o.dirty0 = 1'b1;
					way0_we_o    = 1'b1;
				end else begin
					tag_o.tag1   = adr.tag;
					tag_o.dirty1 = 1'b1;
					way1_we_o    = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/line_mover.sv
// Load/store engine for cache misses. Streams one four-word line between a
// way RAM and backing memory, one four-phase handshake per word, then
// updates the tag line of the set. Runs one command at a time.
`timescale 1ns/1ps
`default_nettype none

module line_mover (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire cache_pkg::line_cmd_t    cmd_i,
	output logic                         busy_o,
	input  wire cache_pkg::tag_line_t    tag_i,
	output cache_pkg::tag_line_t         tag_o,
	output logic                         tag_we_o,
	output logic [cache_pkg::SET_BITS+cache_pkg::WORD_BITS-1:0] ram_adr_o,
	input  wire logic [31:0]             way0_i,
	input  wire logic [31:0]             way1_i,
	output logic [31:0]                  way_dat_o,
	output logic                         way0_we_o,
	output logic                         way1_we_o,
	output mem_link_pkg::mem_req_t       mem_req_o,
	input  wire mem_link_pkg::mem_rsp_t  mem_rsp_i
);

	import cache_pkg::*;

	// l_rel also covers the RAM read latency before each request
	typedef enum logic [1:0] {
		l_idle,
		l_req,
		l_rel
	} state_t;

	state_t             state;
	line_cmd_t          cmd_q;
	logic [WORD_BITS:0] word_q;
	logic               start;
	logic               last;
	logic               word_done;

	assign start     = cmd_i.fill | cmd_i.spill;
	assign last      = (word_q == (WORD_BITS+1)'(LINE_WORDS));
	assign word_done = (state == l_req) && mem_rsp_i.ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= l_idle;
			word_q <= '0;
		end else begin
			case (state)
			l_idle: begin
				if (start) begin
					word_q <= '0;
					state  <= l_rel;
				end
			end
			l_req: begin
				if (mem_rsp_i.ack) begin
					word_q <= word_q + 1'b1;
					state  <= l_rel;
				end
			end
			l_rel: begin
				if (!mem_rsp_i.ack)
					state <= last ? l_idle : l_req;
			end
			default: state <= l_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == l_idle && start)
			cmd_q <= cmd_i;
	end

	assign busy_o    = (state != l_idle);
	assign ram_adr_o = {cmd_q.set, word_q[WORD_BITS-1:0]};

	//------------------------------------------------------------------------
	// Memory link and RAM writes
	//------------------------------------------------------------------------
	always_comb begin
		mem_req_o.req  = (state == l_req);
		mem_req_o.we   = cmd_q.spill;
		mem_req_o.adr  = {cmd_q.tag, cmd_q.set, word_q[WORD_BITS-1:0]};
		mem_req_o.wdat = cmd_q.way ? way1_i : way0_i;
	end

	assign way_dat_o = mem_rsp_i.rdat;
	assign way0_we_o = word_done & cmd_q.fill & ~cmd_q.way;
	assign way1_we_o = word_done & cmd_q.fill & cmd_q.way;

	// Tag line written once the last handshake has been released
	assign tag_we_o = (state == l_rel) && !mem_rsp_i.ack && last;

	always_comb begin
		tag_o = tag_i;
		if (cmd_q.way) begin
			tag_o.dirty1 = 1'b0;
			if (cmd_q.fill)
				tag_o.tag1 = cmd_q.tag;
		end else begin
			tag_o.dirty0 = 1'b0;
			if (cmd_q.fill)
				tag_o.tag0 = cmd_q.tag;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cache_top.sv
// Top level of the two-way write-back cache. Port 0 of every RAM follows
// the live bus address for the controller, port 1 serves the line mover.
`timescale 1ns/1ps
`default_nettype none

module cache_top (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire cache_pkg::bus_req_t    bus_req_i,
	output cache_pkg::bus_rsp_t         bus_rsp_o,
	output mem_link_pkg::mem_req_t      mem_req_o,
	input  wire mem_link_pkg::mem_rsp_t mem_rsp_i
);

	import cache_pkg::*;

	adr_fields_t                   bus_adr;
	tag_line_t                     tag_rd0;
	tag_line_t                     tag_wr0;
	tag_line_t                     tag_rd1;
	tag_line_t                     tag_wr1;
	logic                          tag_we0;
	logic                          tag_we1;
	logic [31:0]                   way0_rd0;
	logic [31:0]                   way1_rd0;
	logic [31:0]                   way0_rd1;
	logic [31:0]                   way1_rd1;
	logic [31:0]                   way_wr0;
	logic [31:0]                   way_wr1;
	logic                          way0_we0;
	logic                          way1_we0;
	logic                          way0_we1;
	logic                          way1_we1;
	logic [SET_BITS+WORD_BITS-1:0] ls_adr;
	line_cmd_t                     cmd;
	logic                          busy;

	assign bus_adr = bus_req_i.adr;

	cache_dpram #(.adr_width(SET_BITS), .payload_t(tag_line_t)) u_tag_ram (
		.clk(clk),
		.adr0_i(bus_adr.set), .din0_i(tag_wr0), .we0_i(tag_we0), .dout0_o(tag_rd0),
		.adr1_i(ls_adr[SET_BITS+WORD_BITS-1:WORD_BITS]), .din1_i(tag_wr1),
		.we1_i(tag_we1), .dout1_o(tag_rd1)
	);

	// The two ways run side by side on the same addresses
	cache_dpram #(.adr_width(SET_BITS+WORD_BITS), .payload_t(logic [31:0])) u_way0_ram (
		.clk(clk),
		.adr0_i({bus_adr.set, bus_adr.word}), .din0_i(way_wr0), .we0_i(way0_we0),
		.dout0_o(way0_rd0),
		.adr1_i(ls_adr), .din1_i(way_wr1), .we1_i(way0_we1), .dout1_o(way0_rd1)
	);

	cache_dpram #(.adr_width(SET_BITS+WORD_BITS), .payload_t(logic [31:0])) u_way1_ram (
		.clk(clk),
		.adr0_i({bus_adr.set, bus_adr.word}), .din0_i(way_wr0), .we0_i(way1_we0),
		.dout0_o(way1_rd0),
		.adr1_i(ls_adr), .din1_i(way_wr1), .we1_i(way1_we1), .dout1_o(way1_rd1)
	);

	cache_ctrl u_cache_ctrl (
		.clk(clk), .reset(reset),
		.bus_req_i(bus_req_i), .bus_rsp_o(bus_rsp_o),
		.tag_i(tag_rd0), .tag_o(tag_wr0), .tag_we_o(tag_we0),
		.way0_i(way0_rd0), .way1_i(way1_rd0), .way_dat_o(way_wr0),
		.way0_we_o(way0_we0), .way1_we_o(way1_we0),
		.cmd_o(cmd), .busy_i(busy)
	);

	line_mover u_line_mover (
		.clk(clk), .reset(reset),
		.cmd_i(cmd), .busy_o(busy),
		.tag_i(tag_rd1), .tag_o(tag_wr1), .tag_we_o(tag_we1), .ram_adr_o(ls_adr),
		.way0_i(way0_rd1), .way1_i(way1_rd1), .way_dat_o(way_wr1),
		.way0_we_o(way0_we1), .way1_we_o(way1_we1),
		.mem_req_o(mem_req_o), .mem_rsp_i(mem_rsp_i)
	);

endmodule

`default_nettype wire

// File: verification/mem_model.sv
// Backing memory for the cache testbench. Answers the four-phase word
// link with a delay that changes from one handshake to the next.
// The array is loaded and inspected by the testbench.
`timescale 1ns/1ps
`default_nettype none

module mem_model (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire mem_link_pkg::mem_req_t  mem_req_i,
	output mem_link_pkg::mem_rsp_t       mem_rsp_o
);

	logic [31:0] mem [0:65535];
	logic [1:0]  delay_q;
	logic [1:0]  wait_q;

	always @(posedge clk) begin
		if (reset) begin
			mem_rsp_o <= '0;
			delay_q   <= 2'd0;
			wait_q    <= 2'd0;
		end else if (mem_rsp_o.ack) begin
			// Release phase
			if (!mem_req_i.req)
				mem_rsp_o.ack <= 1'b0;
		end else if (mem_req_i.req) begin
			if (wait_q == delay_q) begin
				mem_rsp_o.ack <= 1'b1;
				if (mem_req_i.we)
					mem[mem_req_i.adr] <= mem_req_i.wdat;
				else
					mem_rsp_o.rdat <= mem[mem_req_i.adr];
				wait_q  <= 2'd0;
				delay_q <= delay_q + 2'd1;
			end else begin
				wait_q <= wait_q + 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verification/cache_properties.sv
// Handshake assertions for the cache top level, attached by bind.
// Covers the four-phase memory link and the bus ack.
`timescale 1ns/1ps
`default_nettype none

module cache_properties (
	input wire logic                   clk,
	input wire logic                   reset,
	input wire cache_pkg::bus_req_t    bus_req_i,
	input wire cache_pkg::bus_rsp_t    bus_rsp_o,
	input wire mem_link_pkg::mem_req_t mem_req_o,
	input wire mem_link_pkg::mem_rsp_t mem_rsp_i
);

	// req held until the memory answers
	assert property (@(posedge clk) disable iff (reset)
		mem_req_o.req && !mem_rsp_i.ack |=> mem_req_o.req)
		else $error("memory req dropped before ack");

	assert property (@(posedge clk) disable iff (reset)
		$rose(mem_req_o.req) |-> !mem_rsp_i.ack)
		else $error("memory req raised while ack still high");

	assert property (@(posedge clk) disable iff (reset)
		bus_rsp_o.ack |-> bus_req_i.cyc && bus_req_i.stb)
		else $error("bus ack without an active cycle");

endmodule

bind cache_top cache_properties u_cache_properties (.*);

`default_nettype wire

// File: verification/tb_cache_top.sv
// Testbench for the two-way cache. Applies a table of bus accesses, checks
// reads against a byte-wide shadow of memory and checks spilled lines in
// the memory model. Run through the Verilator script in the project root.
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top;

	import cache_pkg::*;

	localparam int N_TESTS = 17;
	localparam logic [1:0] K_READ = 2'd0;
	localparam logic [1:0] K_WRITE = 2'd1;
	localparam logic [1:0] K_MEMCHK = 2'd2;

	typedef struct packed {
		logic [1:0]  kind;
		logic [15:0] adr;
		logic [3:0]  sel;
		logic [31:0] dat;
		logic        rnd;
	} entry_t;

	logic                   clk;
	logic                   reset;
	bus_req_t               bus_req;
	bus_rsp_t               bus_rsp;
	mem_link_pkg::mem_req_t mem_req;
	mem_link_pkg::mem_rsp_t mem_rsp;
	entry_t                 tests [N_TESTS];
	logic [7:0]             shadow [0:262143];
	logic [31:0]            lfsr;
	int                     errors;
	int                     checks;
	int                     acks;
	int                     accesses;

	cache_top u_cache_top (
		.clk(clk), .reset(reset),
		.bus_req_i(bus_req), .bus_rsp_o(bus_rsp),
		.mem_req_o(mem_req), .mem_rsp_i(mem_rsp)
	);

	mem_model u_mem (
		.clk(clk), .reset(reset), .mem_req_i(mem_req), .mem_rsp_o(mem_rsp)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(negedge clk)
		if (bus_rsp.ack)
			acks++;

	//------------------------------------------------------------------------
	// Helpers
	//------------------------------------------------------------------------
	function automatic logic [15:0] make_adr(int tag, int set, int word);
		return {tag[9:0], set[3:0], word[1:0]};
	endfunction

	function automatic entry_t entry(logic [1:0] kind, logic [15:0] adr, logic [3:0] sel,
		logic [31:0] dat, logic rnd);
		entry_t e;
		e.kind = kind;
		e.adr  = adr;
		e.sel  = sel;
		e.dat  = dat;
		e.rnd  = rnd;
		return e;
	endfunction

	// Power-up memory contents, a function of the full address
	function automatic logic [31:0] fill_word(logic [15:0] a);
		return {a ^ 16'h3c5a, ~a};
	endfunction

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] shadow_word(logic [15:0] a);
		int b;
		b = int'(a) * 4;
		return {shadow[b+3], shadow[b+2], shadow[b+1], shadow[b]};
	endfunction

	task automatic random_word(output logic [31:0] w);
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr = lfsr_step(lfsr);
			w    = {w[30:0], lfsr[0]};
		end
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Starts 1 ns after a rising edge and returns at the same point
	task automatic bus_access(input logic we, input logic [15:0] adr, input logic [3:0] sel,
		input logic [31:0] dat, output logic [31:0] rdat);
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		bus_req.we  = we;
		bus_req.adr = adr;
		bus_req.dat = dat;
		bus_req.sel = sel;
		accesses++;
		do
			@(negedge clk);
		while (!bus_rsp.ack);
		rdat = bus_rsp.dat;
		@(posedge clk);
		#1;
		bus_req = '0;
	endtask

	//------------------------------------------------------------------------
	// Stimulus table
	//------------------------------------------------------------------------
	initial begin
		// Write miss, read back, partial write, read back
		tests[0]  = entry(K_WRITE, make_adr(5, 1, 2), 4'hf, 32'h0, 1'b1);
		tests[1]  = entry(K_READ, make_adr(5, 1, 2), 4'hf, 32'h0, 1'b0);
		tests[2]  = entry(K_WRITE, make_adr(5, 1, 2), 4'b0101, 32'ha5a5_a5a5, 1'b0);
		tests[3]  = entry(K_READ, make_adr(5, 1, 2), 4'hf, 32'h0, 1'b0);
		// Whole line filled from memory
		tests[4]  = entry(K_READ, make_adr(7, 2, 0), 4'hf, 32'h0, 1'b0);
		tests[5]  = entry(K_READ, make_adr(7, 2, 1), 4'hf, 32'h0, 1'b0);
		tests[6]  = entry(K_READ, make_adr(7, 2, 2), 4'hf, 32'h0, 1'b0);
		tests[7]  = entry(K_READ, make_adr(7, 2, 3), 4'hf, 32'h0, 1'b0);
		// A, B, A, C in set 3, B dirty and evicted
		tests[8]  = entry(K_READ, make_adr(11, 3, 0), 4'hf, 32'h0, 1'b0);
		tests[9]  = entry(K_WRITE, make_adr(12, 3, 1), 4'hf, 32'h0, 1'b1);
		tests[10] = entry(K_READ, make_adr(11, 3, 0), 4'hf, 32'h0, 1'b0);
		tests[11] = entry(K_READ, make_adr(13, 3, 2), 4'hf, 32'h0, 1'b0);
		tests[12] = entry(K_MEMCHK, make_adr(12, 3, 0), 4'hf, 32'h0, 1'b0);
		tests[13] = entry(K_READ, make_adr(11, 3, 3), 4'hf, 32'h0, 1'b0);
		tests[14] = entry(K_READ, make_adr(12, 3, 1), 4'hf, 32'h0, 1'b0);
		tests[15] = entry(K_WRITE, make_adr(14, 3, 0), 4'b1100, 32'h0, 1'b1);
		tests[16] = entry(K_READ, make_adr(14, 3, 0), 4'hf, 32'h0, 1'b0);
	end

	// Watchdog sized from the table length
	initial begin
		#(N_TESTS * 200 * 20);
		$display("watchdog expired before all accesses were acknowledged");
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rdat;
		logic [31:0] wdat;
		logic [31:0] fw;
		int          errs_before;
		int          b;

		bus_req  = '0;
		reset    = 1'b1;
		lfsr     = 32'he340;
		errors   = 0;
		checks   = 0;
		acks     = 0;
		accesses = 0;
		for (int a = 0; a < 65536; a++) begin
			fw            = fill_word(16'(a));
			u_mem.mem[a]  = fw;
			shadow[4*a]   = fw[7:0];
			shadow[4*a+1] = fw[15:8];
			shadow[4*a+2] = fw[23:16];
			shadow[4*a+3] = fw[31:24];
		end
		for (int s = 0; s < 16; s++)
			u_cache_top.u_tag_ram.mem[s] = '0;

		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		@(negedge clk);
		check("bus ack after reset", 32'(bus_rsp.ack), 32'd0);
		check("mem req after reset", 32'(mem_req.req), 32'd0);
		@(posedge clk);
		#1;

		for (int i = 0; i < N_TESTS; i++) begin
			errs_before = errors;
			case (tests[i].kind)
			K_WRITE: begin
				wdat = tests[i].dat;
				if (tests[i].rnd)
					random_word(wdat);
				bus_access(1'b1, tests[i].adr, tests[i].sel, wdat, rdat);
				b = int'(tests[i].adr) * 4;
				for (int k = 0; k < 4; k++)
					if (tests[i].sel[k])
						shadow[b+k] = wdat[8*k +: 8];
			end
			K_READ: begin
				bus_access(1'b0, tests[i].adr, 4'hf, 32'h0, rdat);
				check("read data", rdat, shadow_word(tests[i].adr));
			end
			default: begin
				// Spilled line must be in memory
				for (int w = 0; w < 4; w++)
					check("memory word", u_mem.mem[{tests[i].adr[15:2], 2'(w)}],
						shadow_word({tests[i].adr[15:2], 2'(w)}));
			end
			endcase
			$display("test %0d kind %0d adr %h: %s", i, tests[i].kind, tests[i].adr,
				(errors == errs_before) ? "ok" : "mismatch");
		end

		repeat (2) @(posedge clk);
		check("ack count", 32'(acks), 32'(accesses));
		$display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: cache.f
rtl/cache_pkg.sv
rtl/mem_link_pkg.sv
rtl/cache_dpram.sv
rtl/cache_ctrl.sv
rtl/line_mover.sv
rtl/cache_top.sv
verification/mem_model.sv
verification/cache_properties.sv
verification/tb_cache_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_cache_top \
	-f cache.f \
	-o sim_cache

./obj_dir/sim_cache > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
